/* dv/cpuCoreTb.sv */
`timescale 1ns/1ns

`include "cpuSettings.svh"

module cpuCoreTb
    import cpuPkg::*;
();

    localparam int CLOCK_PERIOD = 10;
    localparam int RESET_CYCLES = 2;
    localparam int ROW_COUNT    = 34;

    logic  clock;
    logic  reset;
    logic  step;
    word_t instruction;
    word_t loadData;
    word_t memAddress;
    word_t storeData;
    logic  memWrite;
    logic  memRead;
    word_t currentPc;
    word_t currentSp;
    logic  privileged;

    // One row of stimulus and expected values per clock
    word_t rowInstr [ROW_COUNT];
    word_t rowLoad  [ROW_COUNT];
    logic  rowStep  [ROW_COUNT];
    logic  rowWrite [ROW_COUNT];
    logic  rowRead  [ROW_COUNT];
    word_t rowAddr  [ROW_COUNT];
    word_t rowData  [ROW_COUNT];
    word_t rowPc    [ROW_COUNT];
    word_t rowSp    [ROW_COUNT];
    logic  rowPriv  [ROW_COUNT];

    int          rowCount;
    int          errorCount;
    int          checkCount;
    word_t       top;
    word_t       start;
    word_t       loaded;
    word_t       r1, r2, r3, r4, r5, r6, r7;   // Expected register contents

    cpuCore dut0 (
        .clock (clock), .reset (reset), .step (step), .instruction (instruction),
        .loadData (loadData), .memAddress (memAddress), .storeData (storeData),
        .memWrite (memWrite), .memRead (memRead), .currentPc (currentPc),
        .currentSp (currentSp), .privileged (privileged)
    );

    function automatic word_t encode(opcode_t op, int rd, int ra, int rb, int imm);
        return {op, rd[3:0], ra[3:0], rb[3:0], imm[15:0]};
    endfunction

    task automatic addRow(word_t instr, int wr, int rd, word_t addr, word_t data,
                          word_t pc, word_t sp, int priv);
        if (rowCount < ROW_COUNT) begin
            rowInstr[rowCount] = instr;
            rowLoad[rowCount]  = $urandom();
            rowStep[rowCount]  = 1'b1;
            rowWrite[rowCount] = (wr != 0);
            rowRead[rowCount]  = (rd != 0);
            rowAddr[rowCount]  = addr;
            rowData[rowCount]  = data;
            rowPc[rowCount]    = pc;
            rowSp[rowCount]    = sp;
            rowPriv[rowCount]  = (priv != 0);
        end
        rowCount++;
    endtask

    task automatic checkValue(string name, word_t actual, word_t expected);
        checkCount++;
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic buildTable();
        addRow(encode(STORE, 0, 0, 0, 4), 1, 0, start + 4, start, 1, top, 0);
        addRow(encode(ADDI, 1, 0, 0, 5), 0, 0, 0, 0, 2, top, 0);
        addRow(encode(ADDI, 2, 0, 0, -3), 0, 0, 0, 0, 3, top, 0);
        addRow(encode(ADD, 3, 1, 2, 0), 0, 0, 0, 0, 4, top, 0);
        addRow(encode(SUB, 4, 1, 2, 0), 0, 0, 0, 0, 5, top, 0);
        addRow(encode(AND, 6, 1, 2, 0), 0, 0, 0, 0, 6, top, 0);
        addRow(encode(OR, 7, 1, 2, 0), 0, 0, 0, 0, 7, top, 0);
        addRow(encode(XOR, 5, 1, 2, 0), 0, 0, 0, 0, 8, top, 0);
        addRow(encode(STORE, 3, 0, 0, 0), 0, 0, 0, 0, 8, top, 0);
        rowStep[rowCount - 1] = 1'b0;   // Idle cycle
        addRow(encode(STORE, 3, 0, 0, 0), 1, 0, start, r3, 9, top, 0);
        addRow(encode(STORE, 4, 1, 0, 2), 1, 0, r1 + 2, r4, 10, top, 0);
        addRow(encode(STORE, 5, 0, 0, 8), 1, 0, start + 8, r5, 11, top, 0);
        addRow(encode(STORE, 6, 0, 0, 12), 1, 0, start + 12, r6, 12, top, 0);
        addRow(encode(STORE, 7, 2, 0, -1), 1, 0, r2 - 1, r7, 13, top, 0);
        addRow(encode(LOAD, 8, 0, 0, 16), 0, 1, start + 16, 0, 14, top, 0);
        loaded = rowLoad[rowCount - 1];
        addRow(encode(STORE, 8, 0, 0, 20), 1, 0, start + 20, loaded, 15, top, 0);
        addRow(encode(ADDI, 15, 0, 0, 100), 0, 0, 0, 0, 16, top, 0);   // PC write dropped
        addRow(encode(ADDI, 14, 0, 0, 7), 0, 0, 0, 0, 17, top, 0);     // SP write dropped
        addRow(encode(PUSH, 3, 0, 0, 0), 1, 0, top - 1, r3, 18, top - 1, 0);
        addRow(encode(PUSH, 4, 0, 0, 0), 1, 0, top - 2, r4, 19, top - 2, 0);
        addRow(encode(POP, 9, 0, 0, 0), 0, 1, top - 2, 0, 20, top - 1, 0);
        rowLoad[rowCount - 1] = r4;   // Memory hands back the pushed word
        addRow(encode(STORE, 9, 0, 0, 24), 1, 0, start + 24, r4, 21, top - 1, 0);
        addRow(encode(JUMP, 0, 0, 0, 64), 0, 0, 0, 0, 64, top - 1, 0);
        addRow(encode(BEQ, 0, 1, 1, 8), 0, 0, 0, 0, 72, top - 1, 0);
        addRow(encode(BEQ, 0, 1, 2, 8), 0, 0, 0, 0, 73, top - 1, 0);
        addRow(encode(BEQ, 0, 3, 3, -4), 0, 0, 0, 0, 69, top - 1, 0);
        addRow(encode(TRAP, 0, 0, 0, 0), 0, 0, 0, 0, `CPU_TRAP_VECTOR, top, 1);
        addRow(encode(PUSH, 1, 0, 0, 0), 1, 0, top - 1, r1, 17, top - 1, 1);
        addRow(encode(PUSH, 2, 0, 0, 0), 1, 0, top - 2, r2, 18, top - 2, 1);
        addRow(encode(ADDI, 0, 0, 0, 1), 0, 0, 0, 0, 19, top - 2, 1);
        addRow(encode(CLEARDATA, 0, 0, 0, 0), 0, 0, 0, 0, 20, top, 1);
        addRow(encode(STORE, 0, 0, 0, 0), 1, 0, start, start, 21, top, 1);
        addRow(encode(RETURN, 0, 0, 0, 0), 0, 0, 0, 0, 70, top - 1, 0);   // Back to user SP
        addRow(encode(PUSH, 5, 0, 0, 0), 1, 0, top - 2, r5, 71, top - 2, 0);
    endtask

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #((ROW_COUNT + 10) * CLOCK_PERIOD + RESET_CYCLES * CLOCK_PERIOD);
        $display("Timeout: the instruction sequence did not complete in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        step        = 1'b0;
        instruction = '0;
        loadData    = '0;
        rowCount    = 0;
        errorCount  = 0;
        checkCount  = 0;
        void'($urandom(39));
        top   = `CPU_STACK_TOP;
        start = `CPU_DATA_AREA_START;
        r1 = start + 5;
        r2 = start - 3;
        r3 = r1 + r2;
        r4 = r1 - r2;
        r5 = r1 ^ r2;
        r6 = r1 & r2;
        r7 = r1 | r2;
        buildTable();
        if (rowCount != ROW_COUNT) begin
            $display("The stimulus table holds %0d rows instead of %0d", rowCount, ROW_COUNT);
            errorCount++;
        end

        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        #1;
        checkValue("currentPc", currentPc, 0);
        checkValue("currentSp", currentSp, top);
        checkValue("privileged", {31'b0, privileged}, 0);
        checkValue("memWrite", {31'b0, memWrite}, 0);
        checkValue("memRead", {31'b0, memRead}, 0);

        for (int i = 0; i < ROW_COUNT; i++) begin
            @(negedge clock);
            step        = rowStep[i];
            instruction = rowInstr[i];
            loadData    = rowLoad[i];
            #2;
            checkValue("memWrite", {31'b0, memWrite}, {31'b0, rowWrite[i]});
            checkValue("memRead", {31'b0, memRead}, {31'b0, rowRead[i]});
            if (rowWrite[i] || rowRead[i]) checkValue("memAddress", memAddress, rowAddr[i]);
            if (rowWrite[i]) checkValue("storeData", storeData, rowData[i]);
            @(posedge clock);
            #1;
            checkValue("currentPc", currentPc, rowPc[i]);
            checkValue("currentSp", currentSp, rowSp[i]);
            checkValue("privileged", {31'b0, privileged}, {31'b0, rowPriv[i]});
        end
        @(negedge clock);
        step = 1'b0;

        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* logic/aluExecute.sv */
`timescale 1ns/1ns

module aluExecute
    import cpuPkg::*;
(
    input  word_t  readA,
    input  word_t  readB,
    input  word_t  immediate,
    input  logic   useImmediate,
    input  aluOp_t aluOp,
    output word_t  aluResult,
    output logic   branchTaken
);

    word_t operandB;

    assign operandB = useImmediate ? immediate : readB;   // rb or sign-extended imm

    always_comb begin
        case (aluOp)
            ALU_ADD: begin
                aluResult = readA + operandB;
            end
            ALU_SUB: begin
                aluResult = readA - operandB;
            end
            ALU_AND: begin
                aluResult = readA & operandB;
            end
            ALU_OR: begin
                aluResult = readA | operandB;
            end
            ALU_XOR: begin
                aluResult = readA ^ operandB;
            end
            ALU_PASSB: begin
                aluResult = operandB;
            end
            default: begin
                aluResult = readA + operandB;
            end
        endcase
    end

    // Zero test of ra - rb for BEQ
    assign branchTaken = (readA == readB);

endmodule

/* logic/cpuCore.sv */
`timescale 1ns/1ns

module cpuCore
    import cpuPkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  step,
    input  word_t instruction,
    input  word_t loadData,
    output word_t memAddress,
    output word_t storeData,
    output logic  memWrite,
    output logic  memRead,
    output word_t currentPc,
    output word_t currentSp,
    output logic  privileged
);

    regIndex_t rdIndex;
    regIndex_t raIndex;
    regIndex_t rbIndex;
    word_t     immediate;
    aluOp_t    aluOp;
    wbSel_t    wbSel;
    logic      useImmediate;
    logic      isLoad;
    logic      isStore;
    logic      isPush;
    logic      isPop;
    logic      isJump;
    logic      isBranch;
    logic      isTrap;
    logic      isReturn;
    logic      isClearData;
    word_t     readA;
    word_t     readB;
    word_t     readDest;
    word_t     aluResult;
    logic      branchTaken;
    word_t     linkValue;
    word_t     nextPc;
    word_t     nextSp;

    // Strobes only live while an instruction is being stepped
    assign memWrite  = step & (isStore | isPush);
    assign memRead   = step & (isLoad | isPop);
    assign storeData = readDest;

    instructionDecoder decoder0 (
        .instruction (instruction), .rdIndex (rdIndex), .raIndex (raIndex),
        .rbIndex (rbIndex), .immediate (immediate), .aluOp (aluOp), .wbSel (wbSel),
        .useImmediate (useImmediate), .isLoad (isLoad), .isStore (isStore),
        .isPush (isPush), .isPop (isPop), .isJump (isJump), .isBranch (isBranch),
        .isTrap (isTrap), .isReturn (isReturn), .isClearData (isClearData)
    );

    aluExecute execute0 (
        .readA (readA), .readB (readB), .immediate (immediate),
        .useImmediate (useImmediate), .aluOp (aluOp),
        .aluResult (aluResult), .branchTaken (branchTaken)
    );

    pcStackUnit pcStack0 (
        .clock (clock), .reset (reset), .step (step), .isJump (isJump),
        .isBranch (isBranch), .isTrap (isTrap), .isReturn (isReturn),
        .isPush (isPush), .isPop (isPop), .isClearData (isClearData),
        .branchTaken (branchTaken), .aluResult (aluResult), .immediate (immediate),
        .linkValue (linkValue), .currentPc (currentPc), .currentSp (currentSp),
        .nextPc (nextPc), .nextSp (nextSp), .memAddress (memAddress),
        .privileged (privileged)
    );

    regBank bank0 (
        .clock (clock), .reset (reset), .step (step), .privileged (privileged),
        .raIndex (raIndex), .rbIndex (rbIndex), .rdIndex (rdIndex), .wbSel (wbSel),
        .aluResult (aluResult), .loadData (loadData), .nextPc (nextPc),
        .nextSp (nextSp), .isTrap (isTrap), .isClearData (isClearData),
        .readA (readA), .readB (readB), .readDest (readDest),
        .currentPc (currentPc), .currentSp (currentSp), .linkValue (linkValue)
    );

endmodule

/* logic/cpuPkg.sv */
`include "cpuSettings.svh"

package cpuPkg;

    typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
    typedef logic [3:0] regIndex_t;
    typedef logic [3:0] opcode_t;
    typedef logic [2:0] aluOp_t;
    typedef logic [1:0] wbSel_t;

    // Opcodes in bits 31 to 28
    localparam opcode_t ADD       = 4'd0;
    localparam opcode_t SUB       = 4'd1;
    localparam opcode_t AND       = 4'd2;
    localparam opcode_t OR        = 4'd3;
    localparam opcode_t XOR       = 4'd4;
    localparam opcode_t ADDI      = 4'd5;
    localparam opcode_t LOAD      = 4'd6;
    localparam opcode_t STORE     = 4'd7;
    localparam opcode_t JUMP      = 4'd8;
    localparam opcode_t BEQ       = 4'd9;
    localparam opcode_t PUSH      = 4'd10;
    localparam opcode_t POP       = 4'd11;
    localparam opcode_t TRAP      = 4'd12;
    localparam opcode_t RETURN    = 4'd13;
    localparam opcode_t CLEARDATA = 4'd14;

    localparam aluOp_t ALU_ADD   = 3'd0;
    localparam aluOp_t ALU_SUB   = 3'd1;
    localparam aluOp_t ALU_AND   = 3'd2;
    localparam aluOp_t ALU_OR    = 3'd3;
    localparam aluOp_t ALU_XOR   = 3'd4;
    localparam aluOp_t ALU_PASSB = 3'd5;

    localparam wbSel_t WB_NONE = 2'd0;
    localparam wbSel_t WB_ALU  = 2'd1;
    localparam wbSel_t WB_MEM  = 2'd2;

endpackage

/* logic/cpuSettings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and address width of the core
`define CPU_WORD_WIDTH 32

// Register bank size with r0 to r15 and the privileged stack pointer
`define CPU_REG_COUNT 17

`define CPU_DATA_AREA_START 8192   // Reset value of r0

`define CPU_STACK_TOP {`CPU_WORD_WIDTH{1'b1}}   // Both stacks start here

`define CPU_TRAP_VECTOR 16   // PC after a trap

// Immediate field width inside the instruction word
`define CPU_IMM_WIDTH 16

`endif

/* logic/instructionDecoder.sv */
`timescale 1ns/1ns

module instructionDecoder
    import cpuPkg::*;
(
    input  word_t     instruction,
    output regIndex_t rdIndex,
    output regIndex_t raIndex,
    output regIndex_t rbIndex,
    output word_t     immediate,
    output aluOp_t    aluOp,
    output wbSel_t    wbSel,
    output logic      useImmediate,
    output logic      isLoad,
    output logic      isStore,
    output logic      isPush,
    output logic      isPop,
    output logic      isJump,
    output logic      isBranch,
    output logic      isTrap,
    output logic      isReturn,
    output logic      isClearData
);

    opcode_t opcode;

    assign opcode  = instruction[31:28];
    assign rdIndex = instruction[27:24];
    assign raIndex = instruction[23:20];
    assign rbIndex = instruction[19:16];
    assign immediate = {{($bits(word_t) - 16){instruction[15]}}, instruction[15:0]};

    always_comb begin
        aluOp        = ALU_ADD;
        wbSel        = WB_NONE;
        useImmediate = 1'b0;
        isLoad       = 1'b0;
        isStore      = 1'b0;
        isPush       = 1'b0;
        isPop        = 1'b0;
        isJump       = 1'b0;
        isBranch     = 1'b0;
        isTrap       = 1'b0;
        isReturn     = 1'b0;
        isClearData  = 1'b0;

        case (opcode)
            ADD: begin
                wbSel = WB_ALU;
            end
            SUB: begin
                aluOp = ALU_SUB;
                wbSel = WB_ALU;
            end
            AND: begin
                aluOp = ALU_AND;
                wbSel = WB_ALU;
            end
            OR: begin
                aluOp = ALU_OR;
                wbSel = WB_ALU;
            end
            XOR: begin
                aluOp = ALU_XOR;
                wbSel = WB_ALU;
            end
            ADDI: begin
                wbSel        = WB_ALU;
                useImmediate = 1'b1;
            end
            LOAD: begin
                wbSel        = WB_MEM;
                useImmediate = 1'b1;   // Address is ra + imm
                isLoad       = 1'b1;
            end
            STORE: begin
                useImmediate = 1'b1;
                isStore      = 1'b1;
            end
            JUMP: begin
                aluOp        = ALU_PASSB;   // Target also visible on aluResult
                useImmediate = 1'b1;
                isJump       = 1'b1;
            end
            BEQ:       isBranch = 1'b1;
            PUSH:      isPush = 1'b1;
            POP: begin
                wbSel = WB_MEM;
                isPop = 1'b1;
            end
            TRAP:      isTrap = 1'b1;
            RETURN:    isReturn = 1'b1;
            CLEARDATA: isClearData = 1'b1;
            default: begin
                // Unknown opcode is a no-op and PC still advances
                wbSel = WB_NONE;
            end
        endcase
    end

endmodule

/* logic/pcStackUnit.sv */
`timescale 1ns/1ns

`include "cpuSettings.svh"

module pcStackUnit
    import cpuPkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  step,
    input  logic  isJump,
    input  logic  isBranch,
    input  logic  isTrap,
    input  logic  isReturn,
    input  logic  isPush,
    input  logic  isPop,
    input  logic  isClearData,
    input  logic  branchTaken,
    input  word_t aluResult,
    input  word_t immediate,
    input  word_t linkValue,
    input  word_t currentPc,
    input  word_t currentSp,
    output word_t nextPc,
    output word_t nextSp,
    output word_t memAddress,
    output logic  privileged
);

    word_t spDecrement;

    assign spDecrement = currentSp - word_t'(1);

    always_ff @(posedge clock) begin
        if (reset) begin
            privileged <= 1'b0;
        end else if (step) begin
            if (isTrap) privileged <= 1'b1;
            else if (isReturn) privileged <= 1'b0;
        end
    end

    always_comb begin
        if (isJump) nextPc = immediate;
        else if (isBranch && branchTaken) nextPc = currentPc + immediate;   // Relative
        else if (isTrap) nextPc = word_t'(`CPU_TRAP_VECTOR);
        else if (isReturn) nextPc = linkValue;
        else nextPc = currentPc + word_t'(1);
    end

    always_comb begin
        if (isPush) nextSp = spDecrement;
        else if (isPop) nextSp = currentSp + word_t'(1);
        else if (isClearData) nextSp = `CPU_STACK_TOP;
        else nextSp = currentSp;
    end

    // Push writes below the current top, pop reads at it
    assign memAddress = isPush ? spDecrement : (isPop ? currentSp : aluResult);

endmodule

/* logic/regBank.sv */
`timescale 1ns/1ns

`include "cpuSettings.svh"

module regBank
    import cpuPkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      step,
    input  logic      privileged,
    input  regIndex_t raIndex,
    input  regIndex_t rbIndex,
    input  regIndex_t rdIndex,
    input  wbSel_t    wbSel,
    input  word_t     aluResult,
    input  word_t     loadData,
    input  word_t     nextPc,
    input  word_t     nextSp,
    input  logic      isTrap,
    input  logic      isClearData,
    output word_t     readA,
    output word_t     readB,
    output word_t     readDest,
    output word_t     currentPc,
    output word_t     currentSp,
    output word_t     linkValue
);

    localparam logic [4:0] LINK_SLOT = 5'd13;
    localparam logic [4:0] USER_SP   = 5'd14;
    localparam logic [4:0] PC_SLOT   = 5'd15;
    localparam logic [4:0] PRIV_SP   = 5'd16;

    word_t bank [`CPU_REG_COUNT];

    logic [4:0] spIndex;
    logic       rdIsSpecial;

    assign spIndex   = privileged ? PRIV_SP : USER_SP;
    assign currentSp = bank[spIndex];
    assign currentPc = bank[PC_SLOT];
    assign linkValue = bank[LINK_SLOT];

    // r14 always reads as whichever stack is active
    assign readA    = (raIndex == 4'd14) ? currentSp : bank[{1'b0, raIndex}];
    assign readB    = (rbIndex == 4'd14) ? currentSp : bank[{1'b0, rbIndex}];
    assign readDest = (rdIndex == 4'd14) ? currentSp : bank[{1'b0, rdIndex}];

    assign rdIsSpecial = (rdIndex == 4'd14) || (rdIndex == 4'd15);

    always_ff @(posedge clock) begin
        if (reset) begin
            bank[0]       <= word_t'(`CPU_DATA_AREA_START);
            bank[USER_SP] <= `CPU_STACK_TOP;
            bank[PC_SLOT] <= '0;
            bank[PRIV_SP] <= `CPU_STACK_TOP;
        end else if (step) begin
            bank[PC_SLOT] <= nextPc;
            bank[spIndex] <= nextSp;   // Clear-data already folded into nextSp

            if (!rdIsSpecial) begin
                case (wbSel)
                    WB_ALU: bank[{1'b0, rdIndex}] <= aluResult;
                    WB_MEM: bank[{1'b0, rdIndex}] <= loadData;
                    default: ;
                endcase
            end

            if (isClearData) begin
                bank[0] <= word_t'(`CPU_DATA_AREA_START);
            end
            if (isTrap) begin
                bank[LINK_SLOT] <= currentPc + word_t'(1);   // Return address
            end
        end
    end

endmodule

/* project.f */
+incdir+logic
logic/cpuPkg.sv
logic/instructionDecoder.sv
logic/aluExecute.sv
logic/pcStackUnit.sv
logic/regBank.sv
logic/cpuCore.sv
dv/cpuCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the cpuCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f project.f --top-module cpuCoreTb -o cpuCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/cpuCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "Testbench reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
